/* list.f */
common/busPkg.sv
common/cromPkg.sv
nxd/ioNxd.sv
nxd/cromDecode.sv
hdl/busDecode.sv
hdl/ioRegBank.sv
hdl/intrVector.sv
hdl/busReturn.sv
hdl/ioBusTop.sv
sim/ioBusTb.sv

/* Bender.yml */
package:
  name: io_bus

sources:
  - common/busPkg.sv
  - common/cromPkg.sv
  - nxd/ioNxd.sv
  - nxd/cromDecode.sv
  - hdl/busDecode.sv
  - hdl/ioRegBank.sv
  - hdl/intrVector.sv
  - hdl/busReturn.sv
  - hdl/ioBusTop.sv
  - target: simulation
    files:
      - sim/ioBusTb.sv

/* sim/ioBusTb.sv */
/* Testbench for ioBusTop, checks run as concurrent assertions on the bus ports
   Random data comes from a fixed seed, so every run sees the same sequence */
`timescale 1ns/1ps

module ioBusTb import busPkg::*, cromPkg::*; ();

   // DUT configuration
   localparam int                     nxdCount   = 10;
   localparam logic [ctlNumWidth-1:0] devCtl     = 4'd3;
   localparam logic [ioAddrWidth-1:0] devBase    = 18'o776000;
   localparam int                     numRegs    = 8;
   localparam int                     ackDelay   = 3;
   localparam logic [busWidth-1:0]    vectorBase = 36'o240;
   localparam int                     clkPeriod  = 40;

   // Cycle budget per test step
   localparam int bankCycles  = ackDelay + 8;
   localparam int toCycles    = nxdCount + 12;
   localparam int limitCycles = 20 + 2 * numRegs * bankCycles + 2 * toCycles + 40;

   logic                  clk;
   logic                  rst;
   logic                  cpuReq;
   busAddrT               cpuAddr;
   logic [busWidth-1:0]   cpuDataO;
   logic [cromWidth-1:0]  crom;
   logic [levelWidth-1:0] intReq;
   logic                  cpuAck;
   logic [busWidth-1:0]   cpuDataI;
   logic                  ioWait;
   logic                  ioBusy;

   // Cycle kind and expectations, driven with the request
   logic                  bankCyc;
   logic                  toCyc;
   logic                  vecOn;
   logic                  checkRead;
   logic [busWidth-1:0]   expData;
   logic                  clrStrobe;
   logic                  wruEnd;
   logic [7:0]            waitRun;
   logic [31:0]           lfsr;
   logic [busWidth-1:0]   shadow [numRegs];
   logic                  written [numRegs];

   ioBusTop #(
      .nxdCount   (nxdCount),
      .devCtl     (devCtl),
      .devBase    (devBase),
      .numRegs    (numRegs),
      .ackDelay   (ackDelay),
      .vectorBase (vectorBase)
   ) dut0 (
      .clk      (clk),
      .rst      (rst),
      .cpuReq   (cpuReq),
      .cpuAddr  (cpuAddr),
      .cpuDataO (cpuDataO),
      .crom     (crom),
      .intReq   (intReq),
      .cpuAck   (cpuAck),
      .cpuDataI (cpuDataI),
      .ioWait   (ioWait),
      .ioBusy   (ioBusy)
   );

   initial
   begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   // Length of the current ioWait run
   always @(posedge clk)
   begin
      if (rst || !ioWait)
         waitRun <= '0;
      else
         waitRun <= waitRun + 1'b1;
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic failNow(input string msg);
      $display("ERROR %0t: %s", $time, msg);
      $display("TEST FAIL");
      $fatal(1, "stopping after the first failed check");
   endtask

   // Galois LFSR, one step per bit taken
   function automatic logic [busWidth-1:0] nextBits(input int n);
      logic [busWidth-1:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[busWidth-2:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
      end
      return v;
   endfunction

   // Highest pending level wins, four words per vector
   function automatic logic [busWidth-1:0] vectorFor(input logic [levelWidth-1:0] lv);
      for (int i = levelWidth - 1; i >= 0; i--)
         if (lv[i])
            return vectorBase + busWidth'(i * 4);
      return '0;
   endfunction

   function automatic logic [cromWidth-1:0] clearWord();
      logic [cromWidth-1:0] w;
      w = '0;
      w[specEnBit] = 1'b1;
      w[specSelMsb:specSelLsb] = specClrIoLat;
      return w;
   endfunction

   function automatic logic [cromWidth-1:0] wruEndWord();
      logic [cromWidth-1:0] w;
      w = '0;
      w[cromAddrMsb:cromAddrLsb] = wruDoneAddr;
      return w;
   endfunction

   // Edge value of cpuAck, before this edge's updates
   task automatic waitAck();
      do @(posedge clk); while (!cpuAck);
   endtask

   // One microcode word, then idle words
   task automatic microStrobe(input logic [cromWidth-1:0] w, input logic clr,
                              input logic wend);
      @(posedge clk);
      crom      <= w;
      clrStrobe <= clr;
      wruEnd    <= wend;
      @(posedge clk);
      crom      <= '0;
      clrStrobe <= 1'b0;
      wruEnd    <= 1'b0;
      repeat (2) @(posedge clk);
   endtask

   ////////////////////////////////////////////////////////////
   // Bus cycles
   ////////////////////////////////////////////////////////////

   task automatic bankCycle(input logic wr, input int idx, input logic [busWidth-1:0] data);
      busAddrT a;
      a = '0;
      a.ioView.flags.io    = 1'b1;
      a.ioView.flags.read  = ~wr;
      a.ioView.flags.write = wr;
      a.ioView.ctlNum      = devCtl;
      a.ioView.regAddr     = devBase + ioAddrWidth'(idx);
      @(posedge clk);
      cpuReq    <= 1'b1;
      cpuAddr   <= a;
      cpuDataO  <= data;
      bankCyc   <= 1'b1;
      checkRead <= ~wr;
      expData   <= shadow[idx];
      waitAck();
      cpuReq    <= 1'b0;
      cpuAddr   <= '0;
      bankCyc   <= 1'b0;
      checkRead <= 1'b0;
      // Microcode clears the IO latch after each cycle
      microStrobe(clearWord(), 1'b1, 1'b0);
   endtask

   task automatic ioWrite(input int idx, input logic [busWidth-1:0] data);
      shadow[idx]  = data;
      written[idx] = 1'b1;
      bankCycle(1'b1, idx, data);
   endtask

   task automatic ioRead(input int idx);
      bankCycle(1'b0, idx, '0);
   endtask

   // Nobody answers; hold until the monitor gives up
   task automatic timeoutCycle(input busAddrT a);
      @(posedge clk);
      cpuReq  <= 1'b1;
      cpuAddr <= a;
      toCyc   <= 1'b1;
      do @(posedge clk); while (ioWait);
      cpuReq  <= 1'b0;
      cpuAddr <= '0;
      toCyc   <= 1'b0;
      // Busy must survive a few idle cycles
      repeat (4) @(posedge clk);
      microStrobe(clearWord(), 1'b1, 1'b0);
   endtask

   task automatic wruCycle(input logic [levelWidth-1:0] levels);
      busAddrT a;
      a = '0;
      a.ioView.flags.io  = 1'b1;
      a.ioView.flags.wru = 1'b1;
      @(posedge clk);
      intReq <= levels;
      @(posedge clk);
      cpuReq    <= 1'b1;
      cpuAddr   <= a;
      checkRead <= 1'b1;
      expData   <= busWidth'(levels);
      waitAck();
      cpuReq    <= 1'b0;
      cpuAddr   <= '0;
      checkRead <= 1'b0;
      repeat (2) @(posedge clk);
      microStrobe(wruEndWord(), 1'b0, 1'b1);
   endtask

   task automatic vectorCycle(input logic [levelWidth-1:0] levels,
                              input logic [levelWidth-1:0] mask);
      busAddrT a;
      a = '0;
      a.vecView.flags.io   = 1'b1;
      a.vecView.flags.vect = 1'b1;
      a.vecView.levels     = mask;
      @(posedge clk);
      intReq <= levels;
      @(posedge clk);
      cpuReq    <= 1'b1;
      cpuAddr   <= a;
      vecOn     <= 1'b1;
      checkRead <= 1'b1;
      expData   <= vectorFor(mask & levels);
      waitAck();
      cpuReq    <= 1'b0;
      checkRead <= 1'b0;
      // Vector flag stays a while after the request
      repeat (3) @(posedge clk);
      cpuAddr <= '0;
      vecOn   <= 1'b0;
      repeat (3) @(posedge clk);
   endtask

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   aResetLow: assert property (@(posedge clk) $fell(rst) |-> !ioWait && !ioBusy && !cpuAck)
      else failNow("outputs not low after reset");
   aReqStart: assert property (@(posedge clk) disable iff (rst)
      $rose(cpuReq) |-> ioWait && ioBusy && !cpuAck)
      else failNow("ioWait or ioBusy missing in the request cycle");
   aAckDelay: assert property (@(posedge clk) disable iff (rst)
      $rose(cpuAck) && bankCyc |-> $past(cpuReq, ackDelay) && !$past(cpuReq, ackDelay + 1))
      else failNow("register bank ack delay wrong");
   aWaitBank: assert property (@(posedge clk) disable iff (rst)
      cpuReq && bankCyc && !cpuAck |-> ioWait)
      else failNow("ioWait low before the bank acked");
   aAckNoWait: assert property (@(posedge clk) disable iff (rst) cpuAck |-> !ioWait)
      else failNow("ioWait high while acked");
   aReadData: assert property (@(posedge clk) disable iff (rst)
      cpuReq && cpuAck && checkRead |-> cpuDataI == expData)
      else failNow($sformatf("cpuDataI %o, expected %o", cpuDataI, expData));
   aNoAck: assert property (@(posedge clk) disable iff (rst) toCyc |-> !cpuAck)
      else failNow("ack on a cycle nobody should answer");
   // One idle cycle plus nxdCount+1 counting
   aTimeout: assert property (@(posedge clk) disable iff (rst)
      $fell(ioWait) && toCyc |-> waitRun == nxdCount + 2 && ioBusy)
      else failNow($sformatf("timeout after %0d wait cycles", waitRun));
   aClrDrop: assert property (@(posedge clk) disable iff (rst)
      clrStrobe && !cpuReq |=> !ioBusy)
      else failNow("ioBusy held after CLRIOLAT");
   aWruHold: assert property (@(posedge clk) disable iff (rst) $past(wruEnd) |-> ioBusy)
      else failNow("ioBusy dropped before wruDone");
   aWruDrop: assert property (@(posedge clk) disable iff (rst) $past(wruEnd, 2) |-> !ioBusy)
      else failNow("ioBusy held after wruDone");
   aVecDrop: assert property (@(posedge clk) disable iff (rst) $fell(vecOn) |=> !ioBusy)
      else failNow("ioBusy held after the vector flag went away");
   // Busy falls only on a microcode event or vector removal
   aBusyHold: assert property (@(posedge clk) disable iff (rst)
      $fell(ioBusy) |-> $past(clrStrobe) || $past(wruEnd, 2) ||
                        ($past(vecOn, 2) && !$past(vecOn)))
      else failNow("ioBusy dropped without a release event");

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial
   begin
      #(2 * limitCycles * clkPeriod);
      $display("Watchdog expired, the tests did not finish in time");
      $display("TEST FAIL");
      $fatal(1, "watchdog");
   end

   initial
   begin
      busAddrT                    a;
      logic [levelWidth-1:0]      levels;
      logic [levelWidth-1:0]      mask;
      rst       = 1'b1;
      cpuReq    = 1'b0;
      cpuAddr   = '0;
      cpuDataO  = '0;
      crom      = '0;
      intReq    = '0;
      bankCyc   = 1'b0;
      toCyc     = 1'b0;
      vecOn     = 1'b0;
      checkRead = 1'b0;
      expData   = '0;
      clrStrobe = 1'b0;
      wruEnd    = 1'b0;
      lfsr      = 32'h7cdd_d192;
      for (int i = 0; i < numRegs; i++)
         written[i] = 1'b0;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      repeat (2) @(posedge clk);

      // Random writes, then read back every written register
      for (int k = 0; k < numRegs; k++)
         ioWrite(int'(nextBits($clog2(numRegs))), nextBits(busWidth));
      for (int i = 0; i < numRegs; i++)
         if (written[i])
            ioRead(i);

      // Unmapped controller
      a = '0;
      a.ioView.flags.io   = 1'b1;
      a.ioView.flags.read = 1'b1;
      a.ioView.ctlNum     = devCtl + 1'b1;
      a.ioView.regAddr    = devBase;
      timeoutCycle(a);

      // WRU, at least one level pending
      levels = levelWidth'(nextBits(levelWidth));
      if (levels == '0)
         levels = 7'b000_0001;
      wruCycle(levels);

      // Vector for a pending level, never all levels pending
      levels = (levelWidth'(nextBits(levelWidth)) & 7'h3f) | 7'h01;
      mask   = levelWidth'(nextBits(levelWidth));
      if ((mask & levels) == '0)
         mask = levels;
      vectorCycle(levels, mask);

      // Vector with no matching level
      a = '0;
      a.vecView.flags.io   = 1'b1;
      a.vecView.flags.vect = 1'b1;
      a.vecView.levels     = ~levels;
      timeoutCycle(a);

      repeat (4) @(posedge clk);
      $display("TEST PASS");
      $finish;
   end

endmodule

/* hdl/ioBusTop.sv */
/* IO bus subsystem top, no memory cycles or arbitration
   CPU holds cpuReq and cpuAddr steady until it drops the request */
`timescale 1ns/1ps

module ioBusTop import busPkg::*, cromPkg::*; #(
   parameter int                     nxdCount   = 10,
   parameter logic [ctlNumWidth-1:0] devCtl     = 4'd3,
   parameter logic [ioAddrWidth-1:0] devBase    = 18'o776000,
   parameter int                     numRegs    = 8,
   parameter int                     ackDelay   = 3,
   parameter logic [busWidth-1:0]    vectorBase = 36'o240
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  cpuReq,
   input  busAddrT               cpuAddr,
   input  logic [busWidth-1:0]   cpuDataO,
   input  logic [cromWidth-1:0]  crom,
   input  logic [levelWidth-1:0] intReq,
   output logic                  cpuAck,
   output logic [busWidth-1:0]   cpuDataI,
   output logic                  ioWait,
   output logic                  ioBusy
);

   localparam int selWidth = $clog2(numRegs);

   // Decoded cycle
   logic                  isIo;
   logic                  isWru;
   logic                  isVect;
   logic                  isWrite;
   logic                  regHit;
   logic [selWidth-1:0]   regSel;
   logic [levelWidth-1:0] vecLevels;

   // Microcode events
   logic                  ioClear;
   logic                  wruDone;

   // Device returns
   logic                  regAck;
   logic [busWidth-1:0]   regData;
   logic                  vecAck;
   logic [busWidth-1:0]   vecData;

   ////////////////////////////////////////////////////////////
   // Decoders
   ////////////////////////////////////////////////////////////

   busDecode #(
      .devCtl  (devCtl),
      .devBase (devBase),
      .numRegs (numRegs)
   ) busDecode0 (
      .cpuAddr   (cpuAddr),
      .isIo      (isIo),
      .isWru     (isWru),
      .isVect    (isVect),
      .isWrite   (isWrite),
      .regHit    (regHit),
      .regSel    (regSel),
      .vecLevels (vecLevels)
   );

   cromDecode cromDecode0 (
      .clk     (clk),
      .rst     (rst),
      .crom    (crom),
      .ioClear (ioClear),
      .wruDone (wruDone)
   );

   ////////////////////////////////////////////////////////////
   // Devices and return path
   ////////////////////////////////////////////////////////////

   ioRegBank #(
      .numRegs  (numRegs),
      .ackDelay (ackDelay)
   ) ioRegBank0 (
      .clk      (clk),
      .rst      (rst),
      .cpuReq   (cpuReq),
      .regHit   (regHit),
      .regSel   (regSel),
      .isWrite  (isWrite),
      .cpuDataO (cpuDataO),
      .regAck   (regAck),
      .regData  (regData)
   );

   intrVector #(
      .vectorBase (vectorBase)
   ) intrVector0 (
      .clk       (clk),
      .rst       (rst),
      .cpuReq    (cpuReq),
      .isWru     (isWru),
      .isVect    (isVect),
      .vecLevels (vecLevels),
      .intReq    (intReq),
      .vecAck    (vecAck),
      .vecData   (vecData)
   );

   busReturn busReturn0 (
      .regAck   (regAck),
      .regData  (regData),
      .vecAck   (vecAck),
      .vecData  (vecData),
      .cpuAck   (cpuAck),
      .cpuDataI (cpuDataI)
   );

   // Timeout and page fault monitor
   ioNxd #(
      .nxdCount (nxdCount)
   ) ioNxd0 (
      .clk     (clk),
      .rst     (rst),
      .cpuReq  (cpuReq),
      .cpuAck  (cpuAck),
      .isIo    (isIo),
      .isWru   (isWru),
      .isVect  (isVect),
      .ioClear (ioClear),
      .wruDone (wruDone),
      .ioWait  (ioWait),
      .ioBusy  (ioBusy)
   );

endmodule

/* hdl/busReturn.sv */
/* Return path from the devices to the CPU
   Register bank wins if both ever ack together */
`timescale 1ns/1ps

module busReturn import busPkg::*; (
   input  logic                regAck,
   input  logic [busWidth-1:0] regData,
   input  logic                vecAck,
   input  logic [busWidth-1:0] vecData,
   output logic                cpuAck,
   output logic [busWidth-1:0] cpuDataI
);

   // Any device answering
   assign cpuAck = regAck | vecAck;

   ////////////////////////////////////////////////////////////
   // Data select
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      if (regAck)
         cpuDataI = regData;
      else if (vecAck)
         cpuDataI = vecData;
      else
         // Idle bus reads zero
         cpuDataI = '0;
   end

endmodule

/* hdl/intrVector.sv */
/* Interrupt responder for WRU and vector cycles
   Level n is bit n of intReq; no pending level means no ack */
`timescale 1ns/1ps

module intrVector import busPkg::*; #(
   parameter logic [busWidth-1:0] vectorBase = 36'o240
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  cpuReq,
   input  logic                  isWru,
   input  logic                  isVect,
   input  logic [levelWidth-1:0] vecLevels,
   input  logic [levelWidth-1:0] intReq,
   output logic                  vecAck,
   output logic [busWidth-1:0]   vecData
);

   logic [levelWidth-1:0] matchLvls;
   logic                  wruHit;
   logic                  vecHit;

   // Vector for the highest set level
   function automatic logic [busWidth-1:0] vecFor(input logic [levelWidth-1:0] lvls);
      logic [busWidth-1:0] vec;
      vec = vectorBase;
      for (int i = 0; i < levelWidth; i++)
         if (lvls[i])
            vec = vectorBase + busWidth'(4 * i);
      return vec;
   endfunction

   // Pending levels the CPU asks about
   assign matchLvls = vecLevels & intReq;

   assign wruHit = cpuReq & isWru & (|intReq);
   assign vecHit = cpuReq & isVect & (|matchLvls);

   ////////////////////////////////////////////////////////////
   // Ack one cycle after the request
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
         vecAck <= 1'b0;
      else
         vecAck <= wruHit | vecHit;
   end

   // Returned word, levels in low bits for WRU
   always_ff @(posedge clk)
   begin
      if (isWru)
         vecData <= busWidth'(intReq);
      else
         vecData <= vecFor(matchLvls);
   end

endmodule

/* hdl/ioRegBank.sv */
/* Register bank device, acks ackDelay cycles after a hit, ackDelay >= 1
   Registers power up unknown; writes land on the first ack cycle */
`timescale 1ns/1ps

module ioRegBank import busPkg::*; #(
   parameter int numRegs  = 8,
   parameter int ackDelay = 3
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       cpuReq,
   input  logic                       regHit,
   input  logic [$clog2(numRegs)-1:0] regSel,
   input  logic                       isWrite,
   input  logic [busWidth-1:0]        cpuDataO,
   output logic                       regAck,
   output logic [busWidth-1:0]        regData
);

   localparam int dlyWidth = $clog2(ackDelay + 1);

   logic [busWidth-1:0] regFile [numRegs];
   logic [dlyWidth-1:0] dlyCnt;
   logic                active;
   logic                ackPrev;
   logic                firstAck;

   // Matching request held by the CPU
   assign active = cpuReq & regHit;

   ////////////////////////////////////////////////////////////
   // Acknowledge delay
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         dlyCnt  <= '0;
         regAck  <= 1'b0;
         ackPrev <= 1'b0;
      end
      else
      begin
         ackPrev <= regAck;
         if (!active)
         begin
            // Ready for the next hit
            dlyCnt <= '0;
            regAck <= 1'b0;
         end
         else if (!regAck)
         begin
            if (dlyCnt == dlyWidth'(ackDelay - 1))
               regAck <= 1'b1;
            else
               dlyCnt <= dlyCnt + 1'b1;
         end
      end
   end

   // Only once per bus cycle
   assign firstAck = regAck & ~ackPrev;

   // Register file write
   always_ff @(posedge clk)
   begin
      if (firstAck & isWrite)
         regFile[regSel] <= cpuDataO;
   end

   // Read data, valid with ack
   assign regData = regFile[regSel];

endmodule

/* hdl/busDecode.sv */
/* Address decode for one register bank and the interrupt cycles
   numRegs must be a power of two */
`timescale 1ns/1ps

module busDecode import busPkg::*; #(
   parameter logic [ctlNumWidth-1:0] devCtl  = 4'd3,
   parameter logic [ioAddrWidth-1:0] devBase = 18'o776000,
   parameter int                     numRegs = 8
) (
   input  busAddrT                     cpuAddr,
   output logic                        isIo,
   output logic                        isWru,
   output logic                        isVect,
   output logic                        isWrite,
   output logic                        regHit,
   output logic [$clog2(numRegs)-1:0]  regSel,
   output logic [levelWidth-1:0]       vecLevels
);

   localparam int selWidth = $clog2(numRegs);

   logic                   plainIo;
   logic                   ctlMatch;
   logic [ioAddrWidth-1:0] regOffset;

   // Cycle flags
   assign isIo    = cpuAddr.ioView.flags.io;
   assign isWru   = cpuAddr.ioView.flags.io & cpuAddr.ioView.flags.wru;
   assign isVect  = cpuAddr.ioView.flags.io & cpuAddr.ioView.flags.vect;
   assign isWrite = cpuAddr.ioView.flags.write;

   // Neither WRU nor vector
   assign plainIo = isIo & ~cpuAddr.ioView.flags.wru & ~cpuAddr.ioView.flags.vect;

   ////////////////////////////////////////////////////////////
   // Register bank select
   ////////////////////////////////////////////////////////////

   assign ctlMatch = (cpuAddr.ioView.ctlNum == devCtl);

   // Below base wraps to a large offset
   assign regOffset = cpuAddr.ioView.regAddr - devBase;

   assign regHit = plainIo & ctlMatch & (regOffset < ioAddrWidth'(numRegs));
   assign regSel = regOffset[selWidth-1:0];

   // Level mask for vector cycles
   assign vecLevels = cpuAddr.vecView.levels;

endmodule

/* nxd/cromDecode.sv */
/* Microcode decode for the IO monitor
   wruDone lags the matching ROM word by one cycle */
`timescale 1ns/1ps

module cromDecode import cromPkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [cromWidth-1:0] crom,
   output logic                 ioClear,
   output logic                 wruDone
);

   logic [2:0]  specSel;
   logic [11:0] nextAddr;

   // Fields of interest
   assign specSel  = crom[specSelMsb:specSelLsb];
   assign nextAddr = crom[cromAddrMsb:cromAddrLsb];

   // CLRIOLAT special function
   assign ioClear = crom[specEnBit] & (specSel == specClrIoLat);

   ////////////////////////////////////////////////////////////
   // End of WRU microcode
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
         wruDone <= 1'b0;
      else
         wruDone <= (nextAddr == wruDoneAddr);
   end

endmodule

/* nxd/ioNxd.sv */
/* Non-existent-device monitor, expects nxdCount of 1 or more
   Busy only clears on microcode events or a clear strobe while idle */
`timescale 1ns/1ps

module ioNxd #(
   parameter int nxdCount = 10
) (
   input  logic clk,
   input  logic rst,
   input  logic cpuReq,
   input  logic cpuAck,
   input  logic isIo,
   input  logic isWru,
   input  logic isVect,
   input  logic ioClear,
   input  logic wruDone,
   output logic ioWait,
   output logic ioBusy
);

   localparam int cntWidth = $clog2(nxdCount + 1);

   // FSM states
   localparam logic [2:0] stIdle   = 3'd0;
   localparam logic [2:0] stCount  = 3'd1;
   localparam logic [2:0] stAckIo  = 3'd2;
   localparam logic [2:0] stAckWru = 3'd3;
   localparam logic [2:0] stAckVec = 3'd4;
   localparam logic [2:0] stNoAck  = 3'd5;

   logic [2:0]          state;
   logic [cntWidth-1:0] nxdCnt;
   logic                cycWru;
   logic                cycVect;
   logic                busy;
   logic                ioStart;

   // Outstanding IO request, nobody answered yet
   assign ioStart = isIo & cpuReq & ~cpuAck;

   ////////////////////////////////////////////////////////////
   // Monitor FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state   <= stIdle;
         nxdCnt  <= '0;
         cycWru  <= 1'b0;
         cycVect <= 1'b0;
         busy    <= 1'b0;
      end
      else
      begin
         case (state)
            // New cycle, remember its kind
            stIdle:
            begin
               if (ioStart)
               begin
                  cycWru  <= isWru;
                  cycVect <= isVect;
                  busy    <= 1'b1;
                  nxdCnt  <= cntWidth'(nxdCount);
                  state   <= stCount;
               end
               // Drops busy left by a timed out cycle
               else if (ioClear)
                  busy <= 1'b0;
            end
            // Count down until ack or timeout
            stCount:
            begin
               if (cpuAck)
               begin
                  if (cycWru)
                     state <= stAckWru;
                  else if (cycVect)
                     state <= stAckVec;
                  else
                     state <= stAckIo;
               end
               else if (nxdCnt != '0)
                  nxdCnt <= nxdCnt - 1'b1;
               else
                  state <= stNoAck;
            end
            // Microcode clears the IO latch
            stAckIo:
            begin
               if (ioClear)
               begin
                  busy  <= 1'b0;
                  state <= stIdle;
               end
            end
            // End of WRU microcode
            stAckWru:
            begin
               if (wruDone)
               begin
                  busy  <= 1'b0;
                  state <= stIdle;
               end
            end
            // Vector flag removed by the CPU
            stAckVec:
            begin
               if (!isVect)
               begin
                  busy  <= 1'b0;
                  state <= stIdle;
               end
            end
            // Timed out; a WRU releases busy and waits for its flag to go
            stNoAck:
            begin
               if (cycWru)
               begin
                  busy <= 1'b0;
                  if (!isWru)
                     state <= stIdle;
               end
               else
                  state <= stIdle;
            end
            default:
               state <= stIdle;
         endcase
      end
   end

   // Busy shows in the request cycle already
   assign ioBusy = (ioStart & (state == stIdle)) | busy;

   // CPU stalls while idle or counting
   assign ioWait = ioStart & ((state == stIdle) | (state == stCount));

endmodule

/* common/cromPkg.sv */
/* Control ROM fields as seen by the IO logic only
   Bit 107 is the MSB of the next-address field */
package cromPkg;

   // Full microcode word
   localparam int cromWidth = 108;

   // Next microcode address, 12 bits
   localparam int cromAddrMsb = 107;
   localparam int cromAddrLsb = 96;

   ////////////////////////////////////////////////////////////
   // Special function field
   ////////////////////////////////////////////////////////////

   // Enable for the special select
   localparam int specEnBit = 70;

   // Select code, 3 bits
   localparam int specSelMsb = 69;
   localparam int specSelLsb = 67;

   // Clear IO latch
   localparam logic [2:0] specClrIoLat = 3'd5;

   // Last microinstruction of the WRU sequence
   localparam logic [11:0] wruDoneAddr = 12'o3726;

endpackage

/* common/busPkg.sv */
/* Bus address word with the flags in the top 14 bits, MSB first.
   Layout is private to this subsystem and not the full backplane map */
package busPkg;

   // Word and field widths
   localparam int busWidth    = 36;
   localparam int ioAddrWidth = 18;
   localparam int ctlNumWidth = 4;
   localparam int levelWidth  = 7;

   // Flag bits in the top of the address word
   typedef struct packed {
      logic [2:0] pad0;
      logic       read;
      logic       pad1;
      logic       write;
      logic       io;
      logic       wru;
      logic       vect;
      logic [3:0] pad2;
      logic       phys;
   } busFlagsT;

   ////////////////////////////////////////////////////////////
   // Two readings of the same address word
   ////////////////////////////////////////////////////////////

   // Plain IO cycle
   typedef struct packed {
      busFlagsT                 flags;
      logic [ctlNumWidth-1:0]   ctlNum;
      logic [ioAddrWidth-1:0]   regAddr;
   } ioViewT;

   // WRU and vector cycles
   // Level mask sits in the low bits
   typedef struct packed {
      busFlagsT                 flags;
      logic [14:0]              pad;
      logic [levelWidth-1:0]    levels;
   } vecViewT;

   typedef union packed {
      ioViewT  ioView;
      vecViewT vecView;
   } busAddrT;

endpackage
